//--- verilog/sha512_const_pkg.sv
package sha512_const_pkg;

  // --------------------------------------------------------------------
  // Word and block geometry
  // --------------------------------------------------------------------

  // One SHA-512 word
  localparam int word_width = 64;

  // Message block is sixteen words
  localparam int block_width = 16 * word_width;

  // Chaining digest is eight words
  localparam int digest_width = 8 * word_width;

  // Rounds per block and the index that walks them
  localparam int num_rounds      = 80;
  localparam int round_idx_width = 7;

  // --------------------------------------------------------------------
  // Round constants K0..K79
  // --------------------------------------------------------------------

  // First 64 bits of the fractional parts of the cube roots
  // of the first eighty primes
  localparam logic [word_width-1:0] round_k [num_rounds] = '{
    64'h428a2f98d728ae22, 64'h7137449123ef65cd, 64'hb5c0fbcfec4d3b2f, 64'he9b5dba58189dbbc,
    64'h3956c25bf348b538, 64'h59f111f1b605d019, 64'h923f82a4af194f9b, 64'hab1c5ed5da6d8118,
    64'hd807aa98a3030242, 64'h12835b0145706fbe, 64'h243185be4ee4b28c, 64'h550c7dc3d5ffb4e2,
    64'h72be5d74f27b896f, 64'h80deb1fe3b1696b1, 64'h9bdc06a725c71235, 64'hc19bf174cf692694,
    64'he49b69c19ef14ad2, 64'hefbe4786384f25e3, 64'h0fc19dc68b8cd5b5, 64'h240ca1cc77ac9c65,
    64'h2de92c6f592b0275, 64'h4a7484aa6ea6e483, 64'h5cb0a9dcbd41fbd4, 64'h76f988da831153b5,
    64'h983e5152ee66dfab, 64'ha831c66d2db43210, 64'hb00327c898fb213f, 64'hbf597fc7beef0ee4,
    64'hc6e00bf33da88fc2, 64'hd5a79147930aa725, 64'h06ca6351e003826f, 64'h142929670a0e6e70,
    64'h27b70a8546d22ffc, 64'h2e1b21385c26c926, 64'h4d2c6dfc5ac42aed, 64'h53380d139d95b3df,
    64'h650a73548baf63de, 64'h766a0abb3c77b2a8, 64'h81c2c92e47edaee6, 64'h92722c851482353b,
    64'ha2bfe8a14cf10364, 64'ha81a664bbc423001, 64'hc24b8b70d0f89791, 64'hc76c51a30654be30,
    64'hd192e819d6ef5218, 64'hd69906245565a910, 64'hf40e35855771202a, 64'h106aa07032bbd1b8,
    64'h19a4c116b8d2d0c8, 64'h1e376c085141ab53, 64'h2748774cdf8eeb99, 64'h34b0bcb5e19b48a8,
    64'h391c0cb3c5c95a63, 64'h4ed8aa4ae3418acb, 64'h5b9cca4f7763e373, 64'h682e6ff3d6b2b8a3,
    64'h748f82ee5defb2fc, 64'h78a5636f43172f60, 64'h84c87814a1f0ab72, 64'h8cc702081a6439ec,
    64'h90befffa23631e28, 64'ha4506cebde82bde9, 64'hbef9a3f7b2c67915, 64'hc67178f2e372532b,
    64'hca273eceea26619c, 64'hd186b8c721c0c207, 64'heada7dd6cde0eb1e, 64'hf57d4f7fee6ed178,
    64'h06f067aa72176fba, 64'h0a637dc5a2c898a6, 64'h113f9804bef90dae, 64'h1b710b35131c471b,
    64'h28db77f523047d84, 64'h32caab7b40c72493, 64'h3c9ebe0a15c9bebc, 64'h431d67c49c100d4c,
    64'h4cc5d4becb3e42b6, 64'h597f299cfc657e2a, 64'h5fcb6fab3ad6faec, 64'h6c44198c4a475817
  };

  // --------------------------------------------------------------------
  // Initial hash value
  // --------------------------------------------------------------------

  // H0 sits in the top word, H7 in the bottom word
  // Square roots of the first eight primes, fractional part
  localparam logic [digest_width-1:0] h_init = {
    64'h6a09e667f3bcc908,
    64'hbb67ae8584caa73b,
    64'h3c6ef372fe94f82b,
    64'ha54ff53a5f1d36f1,
    64'h510e527fade682d1,
    64'h9b05688c2b3e6c1f,
    64'h1f83d9abfb41bd6b,
    64'h5be0cd19137e2179
  };

endpackage

//--- verilog/sha512_types_pkg.sv
package sha512_types_pkg;

  // One SHA-512 word
  typedef logic [sha512_const_pkg::word_width-1:0] word_t;

  // Working variables, a in the top word
  typedef struct packed {
    word_t a;
    word_t b;
    word_t c;
    word_t d;
    word_t e;
    word_t f;
    word_t g;
    word_t h;
  } sha512_state_t;

  // Controller states
  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_ROUNDS,
    CTRL_DONE
  } ctrl_state_e;

  // Per-cycle strobes from the controller to the datapath
  typedef struct packed {
    logic load;    // take a new block
    logic first;   // block opens a message, start from h_init
    logic round;   // advance one round
    logic finish;  // fold working state into digest
  } ctrl_strobe_t;

endpackage

//--- verilog/sha512_w_mem.sv
module sha512_w_mem
(
  input  logic                                      clk,
  input  logic                                      reset_n,
  input  logic                                      zeroize,
  input  sha512_types_pkg::ctrl_strobe_t            strobe,
  input  logic [sha512_const_pkg::block_width-1:0]  block,
  output sha512_types_pkg::word_t                   w_word
);

  import sha512_const_pkg::*;
  import sha512_types_pkg::*;

  // Sliding window, slot 0 holds W[t] for the current round
  word_t [0:15] win_q;
  word_t [0:15] block_words;
  word_t        w_new;

  // Rotate right by n
  function automatic word_t rotr(input word_t x, input int n);
    return (x >> n) | (x << (word_width - n));
  endfunction

  // Small sigma 0 of the schedule
  function automatic word_t small_sigma0(input word_t x);
    return rotr(x, 1) ^ rotr(x, 8) ^ (x >> 7);
  endfunction

  // Small sigma 1 of the schedule
  function automatic word_t small_sigma1(input word_t x);
    return rotr(x, 19) ^ rotr(x, 61) ^ (x >> 6);
  endfunction

  // Block split into words, most significant word lands in slot 0
  assign block_words = block;

  // W[t+16] from W[t+14], W[t+9], W[t+1] and W[t]
  assign w_new = small_sigma1(win_q[14]) + win_q[9] + small_sigma0(win_q[1]) + win_q[0];

  // Oldest word feeds the round
  assign w_word = win_q[0];

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      win_q <= '0;
    else if (zeroize)
      win_q <= '0;
    else if (strobe.load)
      win_q <= block_words;
    else if (strobe.round)
      // Drop the used word and append the next one
      win_q <= {win_q[1:15], w_new};
  end

endmodule

//--- verilog/sha512_compress.sv
module sha512_compress
(
  input  logic                                          clk,
  input  logic                                          reset_n,
  input  logic                                          zeroize,
  input  sha512_types_pkg::ctrl_strobe_t                strobe,
  input  logic [sha512_const_pkg::round_idx_width-1:0]  round_idx,
  input  sha512_types_pkg::word_t                       w_word,
  output logic [sha512_const_pkg::digest_width-1:0]     digest
);

  import sha512_const_pkg::*;
  import sha512_types_pkg::*;

  sha512_state_t state_q;
  sha512_state_t state_next;
  word_t [0:7]   digest_q;
  word_t [0:7]   state_words;
  word_t [0:7]   digest_sum;
  word_t         t1;
  word_t         t2;

  // --------------------------------------------------------------------
  // Round functions
  // --------------------------------------------------------------------

  function automatic word_t rotr(input word_t x, input int n);
    return (x >> n) | (x << (word_width - n));
  endfunction

  function automatic word_t big_sigma0(input word_t x);
    return rotr(x, 28) ^ rotr(x, 34) ^ rotr(x, 39);
  endfunction

  function automatic word_t big_sigma1(input word_t x);
    return rotr(x, 14) ^ rotr(x, 18) ^ rotr(x, 41);
  endfunction

  // Choose f or g by e
  function automatic word_t ch(input word_t x, input word_t y, input word_t z);
    return (x & y) ^ (~x & z);
  endfunction

  // Bitwise majority
  function automatic word_t maj(input word_t x, input word_t y, input word_t z);
    return (x & y) ^ (x & z) ^ (y & z);
  endfunction

  // --------------------------------------------------------------------
  // Datapath
  // --------------------------------------------------------------------

  always_comb
  begin
    t1 = state_q.h + big_sigma1(state_q.e) + ch(state_q.e, state_q.f, state_q.g)
       + round_k[round_idx] + w_word;
    t2 = big_sigma0(state_q.a) + maj(state_q.a, state_q.b, state_q.c);
    // Shift the state down one slot, new words enter at a and e
    state_next.a = t1 + t2;
    state_next.b = state_q.a;
    state_next.c = state_q.b;
    state_next.d = state_q.c;
    state_next.e = state_q.d + t1;
    state_next.f = state_q.e;
    state_next.g = state_q.f;
    state_next.h = state_q.g;
  end

  // Word-wise mod 2^64 addition for the end of the block
  assign state_words = state_q;

  always_comb
  begin
    for (int i = 0; i < 8; i++)
      digest_sum[i] = digest_q[i] + state_words[i];
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state_q  <= '0;
      digest_q <= '0;
    end
    else if (zeroize)
    begin
      state_q  <= '0;
      digest_q <= '0;
    end
    else
    begin
      if (strobe.load)
      begin
        if (strobe.first)
        begin
          // New message, both copies start from the initial hash
          state_q  <= sha512_state_t'(h_init);
          digest_q <= h_init;
        end
        else
          state_q <= sha512_state_t'(digest_q);
      end
      else if (strobe.round)
        state_q <= state_next;

      if (strobe.finish)
        digest_q <= digest_sum;
    end
  end

  assign digest = digest_q;

endmodule

//--- verilog/sha512_ctrl.sv
module sha512_ctrl
(
  input  logic                                          clk,
  input  logic                                          reset_n,
  input  logic                                          zeroize,
  input  logic                                          init_cmd,
  input  logic                                          next_cmd,
  output sha512_types_pkg::ctrl_strobe_t                strobe,
  output logic [sha512_const_pkg::round_idx_width-1:0]  round_idx,
  output logic                                          ready,
  output logic                                          digest_valid
);

  import sha512_const_pkg::*;
  import sha512_types_pkg::*;

  ctrl_state_e                state_q;
  ctrl_state_e                state_next;
  logic [round_idx_width-1:0] round_q;
  logic                       ready_q;
  logic                       valid_q;
  logic                       cmd;
  logic                       last_round;

  assign cmd        = init_cmd | next_cmd;
  assign last_round = (round_q == round_idx_width'(num_rounds - 1));

  // --------------------------------------------------------------------
  // Next state and strobes
  // --------------------------------------------------------------------
  always_comb
  begin
    state_next = state_q;
    strobe     = '0;
    case (state_q)
      CTRL_IDLE:
      begin
        // Init takes priority when both commands arrive together
        if (cmd)
        begin
          strobe.load  = 1'b1;
          strobe.first = init_cmd;
          state_next   = CTRL_ROUNDS;
        end
      end
      CTRL_ROUNDS:
      begin
        strobe.round = 1'b1;
        if (last_round)
          state_next = CTRL_DONE;
      end
      CTRL_DONE:
      begin
        // One cycle for the digest addition
        strobe.finish = 1'b1;
        state_next    = CTRL_IDLE;
      end
      default:
        state_next = CTRL_IDLE;
    endcase
  end

  // --------------------------------------------------------------------
  // State, round counter and status flags
  // --------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state_q <= CTRL_IDLE;
      round_q <= '0;
      ready_q <= 1'b1;
      valid_q <= 1'b0;
    end
    else if (zeroize)
    begin
      state_q <= CTRL_IDLE;
      round_q <= '0;
      ready_q <= 1'b1;
      valid_q <= 1'b0;
    end
    else
    begin
      state_q <= state_next;
      // Counter restarts with each block
      if (strobe.load)
      begin
        round_q <= '0;
        ready_q <= 1'b0;
        valid_q <= 1'b0;
      end
      if (strobe.round)
        round_q <= round_q + 1'b1;
      if (strobe.finish)
      begin
        ready_q <= 1'b1;
        valid_q <= 1'b1;
      end
    end
  end

  assign round_idx    = round_q;
  assign ready        = ready_q;
  assign digest_valid = valid_q;

endmodule

//--- verilog/sha512_core.sv
module sha512_core
(
  input  logic                                       clk,
  input  logic                                       reset_n,
  input  logic                                       zeroize,
  input  logic                                       init_cmd,
  input  logic                                       next_cmd,
  input  logic [sha512_const_pkg::block_width-1:0]   block,
  output logic                                       ready,
  output logic                                       digest_valid,
  output logic [sha512_const_pkg::digest_width-1:0]  digest
);

  import sha512_const_pkg::*;
  import sha512_types_pkg::*;

  // Controller to datapath
  ctrl_strobe_t               strobe;
  logic [round_idx_width-1:0] round_idx;

  // Schedule word for the current round
  word_t                      w_word;

  // Sequencing and handshake
  sha512_ctrl u_ctrl
  (
    .clk          (clk),
    .reset_n      (reset_n),
    .zeroize      (zeroize),
    .init_cmd     (init_cmd),
    .next_cmd     (next_cmd),
    .strobe       (strobe),
    .round_idx    (round_idx),
    .ready        (ready),
    .digest_valid (digest_valid)
  );

  // Message schedule window
  sha512_w_mem u_w_mem
  (
    .clk     (clk),
    .reset_n (reset_n),
    .zeroize (zeroize),
    .strobe  (strobe),
    .block   (block),
    .w_word  (w_word)
  );

  // Rounds and chaining digest
  sha512_compress u_compress
  (
    .clk       (clk),
    .reset_n   (reset_n),
    .zeroize   (zeroize),
    .strobe    (strobe),
    .round_idx (round_idx),
    .w_word    (w_word),
    .digest    (digest)
  );

endmodule

//--- tests/tb_sha512_core.sv
module tb_sha512_core;

  import sha512_const_pkg::*;

  // Run length limits
  localparam int cycle_time     = 10;
  localparam int reset_cycles   = 16;
  localparam int num_tests      = 6;
  localparam int cycles_per_test = 200;
  localparam int watchdog_time  = (num_tests * cycles_per_test + reset_cycles) * cycle_time;
  // Ready must return well within one test slot
  localparam int ready_limit    = 200;

  // --------------------------------------------------------------------
  // FIPS 180-4 padded blocks and digests
  // --------------------------------------------------------------------

  // "abc", pad bit, zeros, 128-bit length of 24
  localparam logic [block_width-1:0] abc_block = {"abc", 8'h80, 864'h0, 128'd24};

  localparam logic [digest_width-1:0] abc_digest = {
    64'hddaf35a193617aba, 64'hcc417349ae204131, 64'h12e6fa4e89a97ea2, 64'h0a9eeee64b55d39a,
    64'h2192992a274fc1a8, 64'h36ba3c23a3feebbd, 64'h454d4423643ce80e, 64'h2a9ac94fa54ca49f
  };

  // 896-bit message, pad bit does not leave room for the length
  localparam logic [block_width-1:0] two_block_1 = {
    "abcdefghbcdefghicdefghijdefghijkefghijklfghijklmghijklmn",
    "hijklmnoijklmnopjklmnopqklmnopqrlmnopqrsmnopqrstnopqrstu",
    8'h80, 120'h0
  };

  // Length block, 896 bits
  localparam logic [block_width-1:0] two_block_2 = {896'h0, 128'd896};

  localparam logic [digest_width-1:0] two_block_digest = {
    64'h8e959b75dae313da, 64'h8cf4f72814fc143f, 64'h8f7779c6eb9f7fa1, 64'h7299aeadb6889018,
    64'h501d289e4900f7e4, 64'h331b99dec4b5433a, 64'hc7d329eeb6dd2654, 64'h5e96e55b874be909
  };

  logic                    clk;
  logic                    reset_n;
  logic                    zeroize;
  logic                    init_cmd;
  logic                    next_cmd;
  logic [block_width-1:0]  block;
  logic                    ready;
  logic                    digest_valid;
  logic [digest_width-1:0] digest;

  sha512_core u_dut
  (
    .clk          (clk),
    .reset_n      (reset_n),
    .zeroize      (zeroize),
    .init_cmd     (init_cmd),
    .next_cmd     (next_cmd),
    .block        (block),
    .ready        (ready),
    .digest_valid (digest_valid),
    .digest       (digest)
  );

  always #5 clk = ~clk;

  // --------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------

  // Inputs change one unit after the rising edge, outputs are settled then
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string test_name, input logic [511:0] expected,
                             input logic [511:0] actual);
    if (expected !== actual)
    begin
      $display("ERROR %s expected %h actual %h", test_name, expected, actual);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  // One-cycle command pulse, returns just after the accepting edge
  task automatic send_cmd(input logic is_init, input logic [block_width-1:0] blk);
    block    = blk;
    init_cmd = is_init;
    next_cmd = !is_init;
    next_cycle();
    init_cmd = 1'b0;
    next_cmd = 1'b0;
  endtask

  // Counts edges until ready rises
  task automatic wait_ready(input string test_name, output int cycles);
    cycles = 0;
    while (1)
    begin
      next_cycle();
      cycles++;
      if (ready)
        break;
      if (cycles >= ready_limit)
      begin
        $display("Timeout in %s, ready never came back", test_name);
        $display("Test failed");
        $fatal(1);
      end
    end
  endtask

  // --------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------

  task automatic test_reset();
    check_value("test_reset", 512'(1'b1), 512'(ready));
    check_value("test_reset", 512'(1'b0), 512'(digest_valid));
    check_value("test_reset", '0, digest);
  endtask

  task automatic test_abc();
    int cycles;
    send_cmd(1'b1, abc_block);
    wait_ready("test_abc", cycles);
    check_value("test_abc", 512'(1'b1), 512'(digest_valid));
    check_value("test_abc", abc_digest, digest);
  endtask

  task automatic test_two_block();
    int cycles;
    send_cmd(1'b1, two_block_1);
    wait_ready("test_two_block", cycles);
    check_value("test_two_block", 512'(1'b1), 512'(digest_valid));
    // Valid drops as soon as the second block is taken
    send_cmd(1'b0, two_block_2);
    check_value("test_two_block", 512'(1'b0), 512'(digest_valid));
    wait_ready("test_two_block", cycles);
    check_value("test_two_block", 512'(1'b1), 512'(digest_valid));
    check_value("test_two_block", two_block_digest, digest);
  endtask

  task automatic test_latency();
    int cycles;
    send_cmd(1'b1, abc_block);
    check_value("test_latency", 512'(1'b0), 512'(ready));
    // 80 round edges then the digest addition edge
    wait_ready("test_latency", cycles);
    check_value("test_latency", 512'(81), 512'(cycles));
  endtask

  task automatic test_busy_ignored();
    int cycles;
    send_cmd(1'b1, abc_block);
    repeat (10)
      next_cycle();
    // Command and new block while busy, both should be ignored
    next_cmd = 1'b1;
    block    = two_block_1;
    next_cycle();
    next_cmd = 1'b0;
    wait_ready("test_busy_ignored", cycles);
    check_value("test_busy_ignored", abc_digest, digest);
  endtask

  task automatic test_zeroize();
    int cycles;
    send_cmd(1'b1, abc_block);
    repeat (30)
      next_cycle();
    zeroize = 1'b1;
    next_cycle();
    zeroize = 1'b0;
    check_value("test_zeroize", 512'(1'b1), 512'(ready));
    check_value("test_zeroize", 512'(1'b0), 512'(digest_valid));
    check_value("test_zeroize", '0, digest);
    // Core must still hash correctly after the clear
    send_cmd(1'b1, abc_block);
    wait_ready("test_zeroize", cycles);
    check_value("test_zeroize", 512'(1'b1), 512'(digest_valid));
    check_value("test_zeroize", abc_digest, digest);
    // Clear again from idle, while a valid digest is on the outputs
    zeroize = 1'b1;
    next_cycle();
    zeroize = 1'b0;
    check_value("test_zeroize", 512'(1'b1), 512'(ready));
    check_value("test_zeroize", 512'(1'b0), 512'(digest_valid));
    check_value("test_zeroize", '0, digest);
  endtask

  // --------------------------------------------------------------------
  // Watchdog and main sequence
  // --------------------------------------------------------------------

  initial
  begin
    #(watchdog_time);
    $display("Simulation ran past its time limit");
    $display("Test failed");
    $fatal(1);
  end

  initial
  begin
    clk      = 1'b0;
    reset_n  = 1'b0;
    zeroize  = 1'b0;
    init_cmd = 1'b0;
    next_cmd = 1'b0;
    block    = '0;
    repeat (reset_cycles)
      @(posedge clk);
    #1;
    reset_n = 1'b1;
    next_cycle();

    test_reset();
    test_abc();
    test_two_block();
    test_latency();
    test_busy_ignored();
    test_zeroize();

    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- sim.f
verilog/sha512_const_pkg.sv
verilog/sha512_types_pkg.sv
verilog/sha512_w_mem.sv
verilog/sha512_compress.sv
verilog/sha512_ctrl.sv
verilog/sha512_core.sv
tests/tb_sha512_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the SHA-512 core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -f sim.f --top-module tb_sha512_core -o tb_sha512_core
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sha512_core > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
  echo "Simulation FAILED"
  exit 1
elif [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

echo "Simulation PASSED"
exit 0
